/* logic/fp_conv_params.svh */
// Double format constants
`ifndef FP_CONV_PARAMS_SVH
`define FP_CONV_PARAMS_SVH

// IEEE-754 double layout
// Sign in the top bit, then the biased exponent, then the fraction
`define DBL_WIDTH 64

// Exponent field width
`define DBL_EXP_W 11

// Fraction field width, hidden bit not counted
`define DBL_FRAC_W 52

// Exponent bias, field value of 1.0
`define DBL_BIAS 1023

// Signed integer side
// Two's complement, same width as the double word
`define LONG_WIDTH 64

// The bits below the 53-bit mantissa of a long
// are exactly DBL_EXP_W wide, so the residue
// reuses the exponent width

`endif

/* logic/fp_conv_pkg.sv */
// Conversion unit types
`include "fp_conv_params.svh"

package fp_conv_pkg;

  // Signed integer word
  typedef logic signed [`LONG_WIDTH-1:0] long_t;

  // Raw double word
  typedef logic [`DBL_WIDTH-1:0] double_t;

  // Mantissa with the hidden bit on top
  typedef logic [`DBL_FRAC_W:0] mant_t;

  // Exponent, also used for the low residue bits of a long
  typedef logic [`DBL_EXP_W-1:0] exp_t;

  // Operation select, 0 is long to double, 1 is double to long
  typedef logic conv_op_t;

  // Long to double FSM
  // step2 clears the fields for a zero operand
  typedef enum logic [2:0] {
    l2d_getin,
    l2d_step0,
    l2d_step1,
    l2d_step2,
    l2d_round,
    l2d_pack,
    l2d_putout
  } l2d_state_t;

  // Double to long FSM
  typedef enum logic [2:0] {
    d2l_getin,
    d2l_unpack,
    d2l_align,
    d2l_sat,
    d2l_putout
  } d2l_state_t;

endpackage

/* logic/long_to_double_small.sv */
// Long to double converter
`timescale 1ns/1ns
`include "fp_conv_params.svh"

module long_to_double_small
  import fp_conv_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  long_t   long_val,
  input  logic    long_cont,
  input  logic    double_cont,
  output double_t double_val,
  output logic    long_ready,
  output logic    double_ready
);

  l2d_state_t state;

  // Sign and magnitude taken at accept
  logic z_s;
  logic [`LONG_WIDTH-1:0] mag_q;

  // Working mantissa, low residue bits and unbiased exponent
  mant_t z_m;
  exp_t z_r;
  exp_t z_e;

  // Magnitude of the incoming operand
  logic [`LONG_WIDTH-1:0] mag;

  // Rounding inputs, read in the round state
  logic guard;
  logic round_bit;
  logic sticky;
  logic round_up;

  // Most negative long maps onto 2^63, still fits unsigned
  assign mag = long_val[`LONG_WIDTH-1] ? -long_val : long_val;

  // Bits below the mantissa once it is normalized
  assign guard = z_r[`DBL_EXP_W-1];
  assign round_bit = z_r[`DBL_EXP_W-2];
  assign sticky = |z_r[`DBL_EXP_W-3:0];

  // Nearest even, ties go up only on an odd mantissa
  assign round_up = guard & (round_bit | sticky | z_m[0]);

  always_ff @(posedge clk)
  begin
    case (state)
      // Wait for an operand
      l2d_getin:
      begin
        long_ready <= 1'b1;
        if (long_ready && long_cont)
        begin
          long_ready <= 1'b0;
          z_s <= long_val[`LONG_WIDTH-1];
          mag_q <= mag;
          // Zero has no leading one to find
          state <= (long_val == '0) ? l2d_step2 : l2d_step0;
        end
      end

      // Split magnitude into mantissa and residue
      l2d_step0:
      begin
        z_m <= mag_q[`LONG_WIDTH-1 -: `DBL_FRAC_W+1];
        z_r <= mag_q[`DBL_EXP_W-1:0];
        z_e <= exp_t'(`LONG_WIDTH - 1);
        // Top bit already set means no shifting
        state <= mag_q[`LONG_WIDTH-1] ? l2d_round : l2d_step1;
      end

      // Normalize, one bit per cycle
      l2d_step1:
      begin
        z_m <= {z_m[`DBL_FRAC_W-1:0], z_r[`DBL_EXP_W-1]};
        z_r <= {z_r[`DBL_EXP_W-2:0], 1'b0};
        z_e <= z_e - 1'b1;
        // Leave as soon as the hidden bit lands
        if (z_m[`DBL_FRAC_W-1])
        begin
          state <= l2d_round;
        end
      end

      // Zero operand, biased exponent comes out as 0
      l2d_step2:
      begin
        z_m <= '0;
        z_e <= -exp_t'(`DBL_BIAS);
        state <= l2d_pack;
      end

      l2d_round:
      begin
        if (round_up)
        begin
          z_m <= z_m + 1'b1;
          // All ones wraps to 1.0 of the next binade
          if (&z_m)
          begin
            z_e <= z_e + 1'b1;
          end
        end
        state <= l2d_pack;
      end

      // Assemble sign, biased exponent and fraction
      l2d_pack:
      begin
        double_val <= {z_s, z_e + exp_t'(`DBL_BIAS), z_m[`DBL_FRAC_W-1:0]};
        state <= l2d_putout;
      end

      // Hold the result until it is taken
      l2d_putout:
      begin
        double_ready <= 1'b1;
        if (double_ready && double_cont)
        begin
          double_ready <= 1'b0;
          state <= l2d_getin;
        end
      end

      default:
      begin
        state <= l2d_getin;
      end
    endcase

    // Reset wins over the FSM, payload keeps its value
    if (rst)
    begin
      state <= l2d_getin;
      long_ready <= 1'b0;
      double_ready <= 1'b0;
    end
  end

endmodule

/* logic/double_to_long_small.sv */
// Double to long converter
`timescale 1ns/1ns
`include "fp_conv_params.svh"

module double_to_long_small
  import fp_conv_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  double_t double_val,
  input  logic    double_cont,
  input  logic    long_cont,
  output long_t   long_val,
  output logic    double_ready,
  output logic    long_ready
);

  d2l_state_t state;

  // Captured operand
  double_t a;

  // Integer being built and its current binary exponent
  long_t z;
  exp_t e;

  // Operand fields
  exp_t a_exp;
  logic [`DBL_FRAC_W-1:0] a_frac;
  logic a_sign;
  logic a_nan;

  assign a_sign = a[`DBL_WIDTH-1];
  assign a_exp = a[`DBL_WIDTH-2 -: `DBL_EXP_W];
  assign a_frac = a[`DBL_FRAC_W-1:0];

  // All ones exponent with a nonzero fraction
  assign a_nan = (&a_exp) && (a_frac != '0);

  always_ff @(posedge clk)
  begin
    case (state)
      d2l_getin:
      begin
        double_ready <= 1'b1;
        if (double_ready && double_cont)
        begin
          double_ready <= 1'b0;
          a <= double_val;
          state <= d2l_unpack;
        end
      end

      // Classify by the biased exponent
      d2l_unpack:
      begin
        if (a_exp >= exp_t'(`DBL_BIAS + `LONG_WIDTH - 1))
        begin
          // 2^63 and up, infinities and NaN
          state <= d2l_sat;
        end
        else if (a_exp < exp_t'(`DBL_BIAS))
        begin
          // Magnitude below one, denormals included
          z <= '0;
          state <= d2l_putout;
        end
        else
        begin
          // Mantissa sits at bit 52, exponent 0 to 62 here
          z <= {{(`LONG_WIDTH-`DBL_FRAC_W-1){1'b0}}, 1'b1, a_frac};
          e <= a_exp - exp_t'(`DBL_BIAS);
          state <= d2l_align;
        end
      end

      // Move the binary point to bit 0, one step per cycle
      d2l_align:
      begin
        if (e > exp_t'(`DBL_FRAC_W))
        begin
          z <= z << 1;
          e <= e - 1'b1;
        end
        else if (e < exp_t'(`DBL_FRAC_W))
        begin
          // Fraction bits fall off the bottom
          z <= z >> 1;
          e <= e + 1'b1;
        end
        else
        begin
          z <= a_sign ? -z : z;
          state <= d2l_putout;
        end
      end

      // Clamp, NaN counts as negative
      d2l_sat:
      begin
        if (a_nan || a_sign)
        begin
          z <= {1'b1, {(`LONG_WIDTH-1){1'b0}}};
        end
        else
        begin
          z <= {1'b0, {(`LONG_WIDTH-1){1'b1}}};
        end
        state <= d2l_putout;
      end

      // Present the integer and wait for the take
      d2l_putout:
      begin
        long_ready <= 1'b1;
        long_val <= z;
        if (long_ready && long_cont)
        begin
          long_ready <= 1'b0;
          state <= d2l_getin;
        end
      end

      default:
      begin
        state <= d2l_getin;
      end
    endcase

    if (rst)
    begin
      state <= d2l_getin;
      double_ready <= 1'b0;
      long_ready <= 1'b0;
    end
  end

endmodule

/* logic/fp_conv_unit.sv */
// Conversion unit top
`timescale 1ns/1ns

module fp_conv_unit
  import fp_conv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  double_t  in_val,
  input  conv_op_t in_op,
  input  logic     in_cont,
  output logic     in_ready,
  output double_t  out_val,
  output logic     out_ready,
  input  logic     out_cont
);

  // One conversion in flight, op kept until its result is taken
  logic busy;
  conv_op_t op_q;

  // Long to double side
  logic l2d_in_cont;
  logic l2d_out_cont;
  logic l2d_in_ready;
  logic l2d_out_ready;
  double_t l2d_val;

  // Double to long side
  logic d2l_in_cont;
  logic d2l_out_cont;
  logic d2l_in_ready;
  logic d2l_out_ready;
  long_t d2l_val;

  // Input side follows the op offered now
  assign in_ready = ~busy & (in_op ? d2l_in_ready : l2d_in_ready);
  assign l2d_in_cont = in_cont & ~busy & ~in_op;
  assign d2l_in_cont = in_cont & ~busy & in_op;

  // Output side follows the latched op
  assign out_ready = busy & (op_q ? d2l_out_ready : l2d_out_ready);
  assign out_val = op_q ? d2l_val : l2d_val;
  assign l2d_out_cont = out_cont & busy & ~op_q;
  assign d2l_out_cont = out_cont & busy & op_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      op_q <= 1'b0;
    end
    else if (in_ready && in_cont)
    begin
      busy <= 1'b1;
      op_q <= in_op;
    end
    else if (out_ready && out_cont)
    begin
      busy <= 1'b0;
    end
  end

  // Both converters see the same operand bits
  long_to_double_small l2d_i (
    .clk          (clk),
    .rst          (rst),
    .long_val     (in_val),
    .long_cont    (l2d_in_cont),
    .double_cont  (l2d_out_cont),
    .double_val   (l2d_val),
    .long_ready   (l2d_in_ready),
    .double_ready (l2d_out_ready)
  );

  double_to_long_small d2l_i (
    .clk          (clk),
    .rst          (rst),
    .double_val   (in_val),
    .double_cont  (d2l_in_cont),
    .long_cont    (d2l_out_cont),
    .long_val     (d2l_val),
    .double_ready (d2l_in_ready),
    .long_ready   (d2l_out_ready)
  );

endmodule

/* verification/fp_conv_unit_sva.sv */
// Conversion unit protocol checks
`timescale 1ns/1ns

module fp_conv_unit_sva
  import fp_conv_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    in_cont,
  input logic    in_ready,
  input double_t out_val,
  input logic    out_ready,
  input logic    out_cont
);

  // Both ready levels low while in reset and for the cycle after it
  reset_quiet: assert property (@(posedge clk) rst |=> (!in_ready && !out_ready))
    else $error("ready level high during or just after reset");

  // Input side opens one cycle after reset is released
  reset_release: assert property (@(posedge clk) $fell(rst) |=> in_ready)
    else $error("in_ready did not rise one cycle after reset");

  // Accept closes the input side at once
  accept_drop: assert property (@(posedge clk) disable iff (rst)
    (in_ready && in_cont) |=> !in_ready)
    else $error("in_ready still high the cycle after an accept");

  // Take closes the output side at once
  take_drop: assert property (@(posedge clk) disable iff (rst)
    (out_ready && out_cont) |=> !out_ready)
    else $error("out_ready still high the cycle after a take");

  // Result held steady until it is taken
  hold_stable: assert property (@(posedge clk) disable iff (rst)
    (out_ready && !out_cont) |=> (out_ready && $stable(out_val)))
    else $error("out_val or out_ready moved under back-pressure");

endmodule

/* verification/fp_conv_unit_tb.sv */
// Conversion unit testbench
`timescale 1ns/1ns
`include "fp_conv_params.svh"

module fp_conv_unit_tb
  import fp_conv_pkg::*;
();

  // Run length bound, worst latency plus handshake slack per test
  localparam int MAX_TESTS = 200;
  localparam int CYCLES_PER_TEST = 80;
  localparam int CYCLE_LIMIT = MAX_TESTS * CYCLES_PER_TEST;
  localparam int RAND_PAIRS = 80;
  localparam real TWO_63 = 9223372036854775808.0;

  logic clk;
  logic rst;
  double_t in_val;
  conv_op_t in_op;
  logic in_cont;
  logic in_ready;
  double_t out_val;
  logic out_ready;
  logic out_cont;

  integer seed;
  int tests;
  int errors;
  int cycles;
  int i;
  logic [63:0] rnd;
  long_t l_op;
  double_t d_op;

  // Rounding corners, carries into the exponent and ties
  logic [63:0] l2d_dir [12] = '{
    64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, 64'hFFFF_FFFF_FFFF_FFFF,
    64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF, 64'h003F_FFFF_FFFF_FFFF,
    64'hFFC0_0000_0000_0001, 64'h0020_0000_0000_0001, 64'h0020_0000_0000_0003,
    64'hFFDF_FFFF_FFFF_FFFD, 64'h7FFF_FFFF_FFFF_FE00, 64'h0000_0000_0000_0400
  };

  // Zeros, fractions, integers, edges near 2^63, infinities, NaN
  logic [63:0] d2l_dir [18] = '{
    64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h3FE0_0000_0000_0000,
    64'hBFE8_0000_0000_0000, 64'h0000_0000_0000_0001, 64'h3FF0_0000_0000_0000,
    64'hBFF8_0000_0000_0000, 64'h4008_0000_0000_0000, 64'h4330_0000_0000_0001,
    64'hC340_0000_0000_0001, 64'h43DF_FFFF_FFFF_FFFF, 64'hC3DF_FFFF_FFFF_FFFF,
    64'h43E0_0000_0000_0000, 64'hC3E0_0000_0000_0000, 64'h7FF0_0000_0000_0000,
    64'hFFF0_0000_0000_0000, 64'h7FF8_0000_0000_0000, 64'hFFF0_0000_0000_0001
  };

  fp_conv_unit fp_conv_unit_i (
    .clk       (clk),
    .rst       (rst),
    .in_val    (in_val),
    .in_op     (in_op),
    .in_cont   (in_cont),
    .in_ready  (in_ready),
    .out_val   (out_val),
    .out_ready (out_ready),
    .out_cont  (out_cont)
  );

  bind fp_conv_unit fp_conv_unit_sva fp_conv_unit_sva_i (
    .clk       (clk),
    .rst       (rst),
    .in_cont   (in_cont),
    .in_ready  (in_ready),
    .out_val   (out_val),
    .out_ready (out_ready),
    .out_cont  (out_cont)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Nearest-even double through the simulator's own integer to real step
  function automatic double_t ref_l2d(input long_t v);
    real r;
    r = v;
    return $realtobits(r);
  endfunction

  // Truncate toward zero, clamp outside the long range
  function automatic long_t ref_d2l(input double_t b);
    real r;
    real t;
    longint res;
    exp_t ex;
    ex = b[`DBL_WIDTH-2 -: `DBL_EXP_W];
    // NaN clamps to the most negative long
    if ((&ex) && (b[`DBL_FRAC_W-1:0] != '0))
      return {1'b1, {(`LONG_WIDTH-1){1'b0}}};
    r = $bitstoreal(b);
    if (r >= TWO_63)
      return {1'b0, {(`LONG_WIDTH-1){1'b1}}};
    if (r < -TWO_63)
      return {1'b1, {(`LONG_WIDTH-1){1'b0}}};
    t = (r < 0.0) ? $ceil(r) : $floor(r);
    res = t;
    return res;
  endfunction

  // One operand in, one result out, with an optional stall before the take
  task automatic run_conv(input conv_op_t op, input logic [63:0] v, input int max_stall);
    double_t expected;
    double_t got;
    int stall;
    expected = op ? ref_d2l(v) : ref_l2d(v);
    stall = (max_stall > 0) ? ($unsigned($random(seed)) % (max_stall + 1)) : 0;
    @(posedge clk);
    in_val <= v;
    in_op <= op;
    in_cont <= 1'b1;
    // in_ready settles by the falling edge
    @(negedge clk);
    while (!in_ready)
      @(negedge clk);
    @(posedge clk);
    in_cont <= 1'b0;
    @(negedge clk);
    while (!out_ready)
      @(negedge clk);
    // Back-pressure stretch
    repeat (stall) @(negedge clk);
    got = out_val;
    @(posedge clk);
    out_cont <= 1'b1;
    @(posedge clk);
    out_cont <= 1'b0;
    tests = tests + 1;
    assert (got === expected)
    else
    begin
      $display("MISMATCH at %0t: %s in=%h got=%h expected=%h",
               $time, op ? "d2l" : "l2d", v, got, expected);
      errors = errors + 1;
    end
    $display("test %0d %s in=%h out=%h stall=%0d %s", tests, op ? "d2l" : "l2d",
             v, got, stall, (got === expected) ? "ok" : "wrong");
  endtask

  // Watchdog
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: no verdict after %0d clock cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    rst = 1'b1;
    in_val = '0;
    in_op = 1'b0;
    in_cont = 1'b0;
    out_cont = 1'b0;
    seed = 99199;
    tests = 0;
    errors = 0;
    cycles = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (i = 0; i < 12; i++)
      run_conv(1'b0, l2d_dir[i], 0);
    for (i = 0; i < 18; i++)
      run_conv(1'b1, d2l_dir[i], 0);

    // Alternate converters under random back-pressure
    for (i = 0; i < RAND_PAIRS; i++)
    begin
      rnd = {$random(seed), $random(seed)};
      // Arithmetic shift spreads the leading zero count
      l_op = $signed(rnd) >>> ($unsigned($random(seed)) % 64);
      run_conv(1'b0, l_op, 6);
      rnd = {$random(seed), $random(seed)};
      d_op[`DBL_WIDTH-1] = rnd[63];
      // Biased exponent 1021 to 1085, a few below one
      d_op[`DBL_WIDTH-2 -: `DBL_EXP_W] = exp_t'(1021 + ($unsigned($random(seed)) % 65));
      d_op[`DBL_FRAC_W-1:0] = rnd[`DBL_FRAC_W-1:0];
      run_conv(1'b1, d_op, 6);
    end

    $display("Done: %0d tests, %0d errors", tests, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+logic
logic/fp_conv_pkg.sv
logic/long_to_double_small.sv
logic/double_to_long_small.sv
logic/fp_conv_unit.sv
verification/fp_conv_unit_sva.sv
verification/fp_conv_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the conversion unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fp_conv_unit_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module fp_conv_unit_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
